/* Makefile */
# Verilator build and run for the SoC simulation shell.

VERILATOR ?= verilator
TOP       ?= sim_top_tb
FILELIST  ?= soc_sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j $(JOBS)

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes.
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass or fail is taken from the log.
run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q '^TEST PASSED$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* logic/axi_xbar.sv */
`timescale 1ns/1ps

module axi_xbar import soc_pkg::*; #(
    parameter addr_t MEM_BASE  = MEM_BASE_DEF,
    parameter int    MEM_WORDS = MEM_WORDS_DEF,
    parameter addr_t UART_BASE = UART_BASE_DEF
) (
    input  logic       clock,
    input  logic       rst_n,
    input  axi_addr_t  m_aw,
    output logic       m_aw_ready,
    input  axi_wdata_t m_w,
    output logic       m_w_ready,
    output axi_bresp_t m_b,
    input  logic       m_b_ready,
    input  axi_addr_t  m_ar,
    output logic       m_ar_ready,
    output axi_rdata_t m_r,
    input  logic       m_r_ready,
    output axi_addr_t  ram_aw,
    input  logic       ram_aw_ready,
    output axi_wdata_t ram_w,
    input  logic       ram_w_ready,
    input  axi_bresp_t ram_b,
    output logic       ram_b_ready,
    output axi_addr_t  ram_ar,
    input  logic       ram_ar_ready,
    input  axi_rdata_t ram_r,
    output logic       ram_r_ready,
    output axi_addr_t  uart_aw,
    input  logic       uart_aw_ready,
    output axi_wdata_t uart_w,
    input  logic       uart_w_ready,
    input  axi_bresp_t uart_b,
    output logic       uart_b_ready,
    output axi_addr_t  uart_ar,
    input  logic       uart_ar_ready,
    input  axi_rdata_t uart_r,
    output logic       uart_r_ready
);

    typedef enum logic [1:0] {IDLE, BUSY_RAM, BUSY_UART, BUSY_ERR} xbar_state_e;

    localparam addr_t MEM_SPAN = addr_t'(4 * MEM_WORDS);

    // Unsigned offset compare also rejects addresses below the base.
    function automatic xbar_state_e decode(addr_t a);
        if (a - MEM_BASE < MEM_SPAN) begin
            return BUSY_RAM;
        end else if (a - UART_BASE < UART_SPAN) begin
            return BUSY_UART;
        end
        return BUSY_ERR;
    endfunction

    xbar_state_e rd_state, wr_state, ar_tgt, aw_tgt;
    logic        live;
    logic        rd_open, wr_open, wr_req;
    logic        ar_sel_ready, aw_sel_ready;

    assign ar_tgt  = decode(m_ar.addr);
    assign aw_tgt  = decode(m_aw.addr);
    // Keeps master readies low until the cycle after reset release.
    assign rd_open = live && rd_state == IDLE;
    assign wr_open = live && wr_state == IDLE;
    assign wr_req  = m_aw.valid && m_w.valid && wr_open;

    always_comb begin
        ram_ar        = m_ar;
        uart_ar       = m_ar;
        ram_ar.valid  = 1'b0;
        uart_ar.valid = 1'b0;
        ar_sel_ready  = 1'b1;
        case (ar_tgt)
            BUSY_RAM: begin
                ram_ar.valid = m_ar.valid && rd_open;
                ar_sel_ready = ram_ar_ready;
            end
            BUSY_UART: begin
                uart_ar.valid = m_ar.valid && rd_open;
                ar_sel_ready  = uart_ar_ready;
            end
            default: ;
        endcase
        m_ar_ready = rd_open && ar_sel_ready;
    end

    always_comb begin
        ram_aw        = m_aw;
        uart_aw       = m_aw;
        ram_w         = m_w;
        uart_w        = m_w;
        ram_aw.valid  = 1'b0;
        uart_aw.valid = 1'b0;
        ram_w.valid   = 1'b0;
        uart_w.valid  = 1'b0;
        aw_sel_ready  = 1'b1;
        case (aw_tgt)
            BUSY_RAM: begin
                ram_aw.valid = wr_req;
                ram_w.valid  = wr_req;
                aw_sel_ready = ram_aw_ready && ram_w_ready;
            end
            BUSY_UART: begin
                uart_aw.valid = wr_req;
                uart_w.valid  = wr_req;
                aw_sel_ready  = uart_aw_ready && uart_w_ready;
            end
            default: ;
        endcase
        // AW and W are accepted together.
        m_aw_ready = wr_req && aw_sel_ready;
        m_w_ready  = m_aw_ready;
    end

    // The error target answers straight from its state.
    always_comb begin
        m_r          = '{valid: 1'b0, data: '0, resp: RESP_OKAY};
        ram_r_ready  = 1'b0;
        uart_r_ready = 1'b0;
        case (rd_state)
            BUSY_RAM: begin
                m_r         = ram_r;
                ram_r_ready = m_r_ready;
            end
            BUSY_UART: begin
                m_r          = uart_r;
                uart_r_ready = m_r_ready;
            end
            BUSY_ERR: m_r = '{valid: 1'b1, data: '0, resp: RESP_DECERR};
            default: ;
        endcase
    end

    always_comb begin
        m_b          = '{valid: 1'b0, resp: RESP_OKAY};
        ram_b_ready  = 1'b0;
        uart_b_ready = 1'b0;
        case (wr_state)
            BUSY_RAM: begin
                m_b         = ram_b;
                ram_b_ready = m_b_ready;
            end
            BUSY_UART: begin
                m_b          = uart_b;
                uart_b_ready = m_b_ready;
            end
            BUSY_ERR: m_b = '{valid: 1'b1, resp: RESP_DECERR};
            default: ;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            live     <= 1'b0;
            rd_state <= IDLE;
            wr_state <= IDLE;
        end else begin
            live <= 1'b1;
            if (m_ar.valid && m_ar_ready) begin
                rd_state <= ar_tgt;
            end else if (m_r.valid && m_r_ready) begin
                rd_state <= IDLE;
            end
            if (m_aw.valid && m_aw_ready) begin
                wr_state <= aw_tgt;
            end else if (m_b.valid && m_b_ready) begin
                wr_state <= IDLE;
            end
        end
    end

    // No slave may answer a request the crossbar did not route.
    a_rd_idle: assert property (@(posedge clock) disable iff (!rst_n)
        rd_state == IDLE |-> !m_r.valid && !ram_r.valid && !uart_r.valid)
        else $error("read response while read path idle");

    a_wr_idle: assert property (@(posedge clock) disable iff (!rst_n)
        wr_state == IDLE |-> !m_b.valid && !ram_b.valid && !uart_b.valid)
        else $error("write response while write path idle");

    a_ar_stable: assert property (@(posedge clock) disable iff (!rst_n)
        m_ar.valid && !m_ar_ready |=> $stable(ar_tgt))
        else $error("read target changed while waiting");

    a_aw_stable: assert property (@(posedge clock) disable iff (!rst_n)
        m_aw.valid && !m_aw_ready |=> $stable(aw_tgt))
        else $error("write target changed while waiting");

endmodule

/* logic/reset_sync.sv */
`timescale 1ns/1ps

module reset_sync import soc_pkg::*; #(
    parameter int STAGES = RST_STAGES_DEF
) (
    input  logic clock,
    input  logic rst_n,
    output logic sync_rst_n
);

    // Needs at least two stages.
    logic [STAGES-1:0] chain;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            chain <= '0;
        end else begin
            chain <= {chain[STAGES-2:0], 1'b1};
        end
    end

    assign sync_rst_n = chain[STAGES-1];

    a_assert_follows: assert property (@(posedge clock) !rst_n |-> !sync_rst_n)
        else $error("sync_rst_n high while rst_n low");

endmodule

/* logic/sim_ram.sv */
`timescale 1ns/1ps

module sim_ram import soc_pkg::*; #(
    parameter int MEM_WORDS = MEM_WORDS_DEF
) (
    input  logic       clock,
    input  logic       rst_n,
    input  axi_addr_t  aw,
    output logic       aw_ready,
    input  axi_wdata_t w,
    output logic       w_ready,
    output axi_bresp_t b,
    input  logic       b_ready,
    input  axi_addr_t  ar,
    output logic       ar_ready,
    output axi_rdata_t r,
    input  logic       r_ready
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    data_t             mem [MEM_WORDS];
    logic [IDX_W-1:0]  rd_idx, wr_idx;
    logic              rd_hs, wr_hs;
    logic              r_valid, b_valid;
    data_t             r_data;

    // Base is aligned to the window, so low word bits index directly.
    assign rd_idx = ar.addr[IDX_W+1:2];
    assign wr_idx = aw.addr[IDX_W+1:2];

    assign ar_ready = !r_valid;
    assign aw_ready = !b_valid;
    assign w_ready  = !b_valid;

    assign rd_hs = ar.valid && ar_ready;
    assign wr_hs = aw.valid && w.valid && aw_ready;

    assign r = '{valid: r_valid, data: r_data, resp: RESP_OKAY};
    assign b = '{valid: b_valid, resp: RESP_OKAY};

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            r_valid <= 1'b0;
            b_valid <= 1'b0;
        end else begin
            if (rd_hs) begin
                r_valid <= 1'b1;
            end else if (r_ready) begin
                r_valid <= 1'b0;
            end
            if (wr_hs) begin
                b_valid <= 1'b1;
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rd_hs) begin
            r_data <= mem[rd_idx];
        end
        if (wr_hs) begin
            for (int i = 0; i < 4; i++) begin
                if (w.strb[i]) begin
                    mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
                end
            end
        end
    end

    a_r_hold: assert property (@(posedge clock) disable iff (!rst_n)
        r.valid && !r_ready |=> r.valid && $stable(r.data))
        else $error("read response dropped before r_ready");

endmodule

/* logic/sim_top.sv */
`timescale 1ns/1ps

module sim_top import soc_pkg::*; #(
    parameter addr_t MEM_BASE  = MEM_BASE_DEF,
    parameter int    MEM_WORDS = MEM_WORDS_DEF,
    parameter addr_t UART_BASE = UART_BASE_DEF
) (
    input  logic       clock,
    input  logic       rst_n,
    input  axi_addr_t  m_aw,
    output logic       m_aw_ready,
    input  axi_wdata_t m_w,
    output logic       m_w_ready,
    output axi_bresp_t m_b,
    input  logic       m_b_ready,
    input  axi_addr_t  m_ar,
    output logic       m_ar_ready,
    output axi_rdata_t m_r,
    input  logic       m_r_ready,
    output logic       uart_out_valid,
    output logic [7:0] uart_out_ch,
    output logic       uart_in_valid,
    input  logic [7:0] uart_in_ch
);

    logic       core_rst_n, uart_rst_n;
    axi_addr_t  ram_aw, ram_ar, uart_aw, uart_ar;
    axi_wdata_t ram_w, uart_w;
    axi_bresp_t ram_b, uart_b;
    axi_rdata_t ram_r, uart_r;
    logic       ram_aw_ready, ram_w_ready, ram_b_ready, ram_ar_ready, ram_r_ready;
    logic       uart_aw_ready, uart_w_ready, uart_b_ready, uart_ar_ready, uart_r_ready;

    // One synchronizer per reset domain.
    reset_sync #(.STAGES(RST_STAGES_DEF)) core_rst_sync (
        .clock(clock), .rst_n(rst_n), .sync_rst_n(core_rst_n)
    );

    reset_sync #(.STAGES(RST_STAGES_DEF)) uart_rst_sync (
        .clock(clock), .rst_n(rst_n), .sync_rst_n(uart_rst_n)
    );

    axi_xbar #(
        .MEM_BASE(MEM_BASE), .MEM_WORDS(MEM_WORDS), .UART_BASE(UART_BASE)
    ) xbar (
        .clock(clock), .rst_n(core_rst_n),
        .m_aw(m_aw), .m_aw_ready(m_aw_ready), .m_w(m_w), .m_w_ready(m_w_ready),
        .m_b(m_b), .m_b_ready(m_b_ready), .m_ar(m_ar), .m_ar_ready(m_ar_ready),
        .m_r(m_r), .m_r_ready(m_r_ready),
        .ram_aw(ram_aw), .ram_aw_ready(ram_aw_ready), .ram_w(ram_w), .ram_w_ready(ram_w_ready),
        .ram_b(ram_b), .ram_b_ready(ram_b_ready), .ram_ar(ram_ar), .ram_ar_ready(ram_ar_ready),
        .ram_r(ram_r), .ram_r_ready(ram_r_ready),
        .uart_aw(uart_aw), .uart_aw_ready(uart_aw_ready),
        .uart_w(uart_w), .uart_w_ready(uart_w_ready),
        .uart_b(uart_b), .uart_b_ready(uart_b_ready),
        .uart_ar(uart_ar), .uart_ar_ready(uart_ar_ready),
        .uart_r(uart_r), .uart_r_ready(uart_r_ready)
    );

    sim_ram #(.MEM_WORDS(MEM_WORDS)) ram (
        .clock(clock), .rst_n(core_rst_n),
        .aw(ram_aw), .aw_ready(ram_aw_ready), .w(ram_w), .w_ready(ram_w_ready),
        .b(ram_b), .b_ready(ram_b_ready), .ar(ram_ar), .ar_ready(ram_ar_ready),
        .r(ram_r), .r_ready(ram_r_ready)
    );

    sim_uart uart (
        .clock(clock), .rst_n(uart_rst_n),
        .aw(uart_aw), .aw_ready(uart_aw_ready), .w(uart_w), .w_ready(uart_w_ready),
        .b(uart_b), .b_ready(uart_b_ready), .ar(uart_ar), .ar_ready(uart_ar_ready),
        .r(uart_r), .r_ready(uart_r_ready),
        .uart_out_valid(uart_out_valid), .uart_out_ch(uart_out_ch),
        .uart_in_valid(uart_in_valid), .uart_in_ch(uart_in_ch)
    );

endmodule

/* logic/sim_uart.sv */
`timescale 1ns/1ps

module sim_uart import soc_pkg::*; (
    input  logic       clock,
    input  logic       rst_n,
    input  axi_addr_t  aw,
    output logic       aw_ready,
    input  axi_wdata_t w,
    output logic       w_ready,
    output axi_bresp_t b,
    input  logic       b_ready,
    input  axi_addr_t  ar,
    output logic       ar_ready,
    output axi_rdata_t r,
    input  logic       r_ready,
    output logic       uart_out_valid,
    output logic [7:0] uart_out_ch,
    output logic       uart_in_valid,
    input  logic [7:0] uart_in_ch
);

    logic      rd_hs, wr_hs, tx_hit;
    logic      r_valid, b_valid;
    data_t     r_data, tx_count;
    axi_resp_e r_resp, b_resp;

    assign ar_ready = !r_valid;
    assign aw_ready = !b_valid;
    assign w_ready  = !b_valid;

    assign rd_hs  = ar.valid && ar_ready;
    assign wr_hs  = aw.valid && w.valid && aw_ready;
    assign tx_hit = wr_hs && aw.addr[3:0] == UART_TX_DATA && w.strb[0];

    // Console request lasts only the handshake cycle.
    assign uart_in_valid = rd_hs && ar.addr[3:0] == UART_RX_DATA;

    assign r = '{valid: r_valid, data: r_data, resp: r_resp};
    assign b = '{valid: b_valid, resp: b_resp};

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            r_valid        <= 1'b0;
            b_valid        <= 1'b0;
            uart_out_valid <= 1'b0;
            tx_count       <= '0;
        end else begin
            if (rd_hs) begin
                r_valid <= 1'b1;
            end else if (r_ready) begin
                r_valid <= 1'b0;
            end
            if (wr_hs) begin
                b_valid <= 1'b1;
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end
            uart_out_valid <= tx_hit;
            if (tx_hit) begin
                tx_count <= tx_count + 32'd1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rd_hs) begin
            case (ar.addr[3:0])
                UART_STATUS: begin
                    r_data <= tx_count;
                    r_resp <= RESP_OKAY;
                end
                UART_RX_DATA: begin
                    r_data <= {24'd0, uart_in_ch};
                    r_resp <= RESP_OKAY;
                end
                default: begin
                    r_data <= '0;
                    r_resp <= RESP_SLVERR;
                end
            endcase
        end
        if (wr_hs) begin
            b_resp <= (aw.addr[3:0] == UART_TX_DATA) ? RESP_OKAY : RESP_SLVERR;
        end
        if (tx_hit) begin
            uart_out_ch <= w.data[7:0];
        end
    end

    a_tx_pulse: assert property (@(posedge clock) disable iff (!rst_n)
        uart_out_valid |=> !uart_out_valid)
        else $error("uart_out_valid held for two cycles");

endmodule

/* logic/soc_pkg.sv */
package soc_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

    // Byte offsets inside the UART window.
    typedef enum logic [3:0] {
        UART_TX_DATA = 4'h0,
        UART_STATUS  = 4'h4,
        UART_RX_DATA = 4'h8
    } uart_reg_e;

    // AW and AR share one layout.
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } axi_addr_t;

    typedef struct packed {
        logic       valid;
        data_t      data;
        logic [3:0] strb;
    } axi_wdata_t;

    typedef struct packed {
        logic      valid;
        data_t     data;
        axi_resp_e resp;
    } axi_rdata_t;

    typedef struct packed {
        logic      valid;
        axi_resp_e resp;
    } axi_bresp_t;

    localparam addr_t UART_SPAN = 32'h0000_0010;

    localparam addr_t MEM_BASE_DEF  = 32'h8000_0000;
    localparam addr_t UART_BASE_DEF = 32'h1000_0000;
    localparam int    MEM_WORDS_DEF = 1024;

    // Synchronizer depth per clock domain.
    localparam int RST_STAGES_DEF = 3;

endpackage

/* soc_sim.f */
logic/soc_pkg.sv
logic/reset_sync.sv
logic/axi_xbar.sv
logic/sim_ram.sv
logic/sim_uart.sv
logic/sim_top.sv
verif/sim_top_tb.sv

/* verif/sim_top_tb.sv */
`timescale 1ns/1ps

module sim_top_tb import soc_pkg::*; ();

    localparam addr_t MEM_BASE  = MEM_BASE_DEF;
    localparam int    MEM_WORDS = MEM_WORDS_DEF;
    localparam addr_t UART_BASE = UART_BASE_DEF;
    localparam int    STAGES    = RST_STAGES_DEF;
    localparam int    POOL      = 16;
    // Rounded up from 16 reset cycles and about 300 transactions of 12 cycles.
    localparam int    TIMEOUT   = 4000;

    logic       clock = 1'b0;
    logic       rst_n = 1'b0;
    axi_addr_t  m_aw = '0;
    axi_addr_t  m_ar = '0;
    axi_wdata_t m_w = '0;
    logic       m_b_ready = 1'b0;
    logic       m_r_ready = 1'b0;
    logic [7:0] uart_in_ch = 8'd0;
    axi_bresp_t m_b;
    axi_rdata_t m_r;
    logic       m_aw_ready, m_w_ready, m_ar_ready;
    logic       uart_out_valid, uart_in_valid;
    logic [7:0] uart_out_ch;

    data_t      ref_mem [MEM_WORDS];
    int         pool_idx [POOL];
    data_t      exp_r_data = '0;
    axi_resp_e  exp_r_resp = RESP_OKAY;
    axi_resp_e  exp_b_resp = RESP_OKAY;
    logic       exp_r_on = 1'b0;
    logic [7:0] last_tx_ch = 8'd0;
    logic [7:0] rx_ch_seen = 8'd0;
    logic       rd_hs, wr_hs, tx_hs, rx_hs;
    int         tx_sent = 0;
    int         ready_pct = 100;
    int         since_rel = 0;
    int         cycles = 0;
    int         errors = 0;
    int         tests_ok = 0;
    int         tests_bad = 0;

    sim_top #(
        .MEM_BASE(MEM_BASE), .MEM_WORDS(MEM_WORDS), .UART_BASE(UART_BASE)
    ) sim_top_inst (
        .clock(clock), .rst_n(rst_n),
        .m_aw(m_aw), .m_aw_ready(m_aw_ready), .m_w(m_w), .m_w_ready(m_w_ready),
        .m_b(m_b), .m_b_ready(m_b_ready), .m_ar(m_ar), .m_ar_ready(m_ar_ready),
        .m_r(m_r), .m_r_ready(m_r_ready),
        .uart_out_valid(uart_out_valid), .uart_out_ch(uart_out_ch),
        .uart_in_valid(uart_in_valid), .uart_in_ch(uart_in_ch)
    );

    always #10 clock = ~clock;

    assign rd_hs = m_ar.valid && m_ar_ready;
    assign wr_hs = m_aw.valid && m_w.valid && m_aw_ready;
    assign tx_hs = wr_hs && m_aw.addr == UART_BASE + 32'(UART_TX_DATA) && m_w.strb[0];
    assign rx_hs = rd_hs && m_ar.addr == UART_BASE + 32'(UART_RX_DATA);

    // Random response back-pressure and console input.
    always @(posedge clock) begin
        m_r_ready  <= ($urandom % 100) < ready_pct;
        m_b_ready  <= ($urandom % 100) < ready_pct;
        uart_in_ch <= 8'($urandom);
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (!rst_n) begin
            since_rel <= 0;
        end else if (since_rel < 255) begin
            since_rel <= since_rel + 1;
        end
        if (rx_hs) begin
            rx_ch_seen <= uart_in_ch;
        end
    end

    always @(posedge clock) begin
        if (cycles >= TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic void report_mismatch(input string sig, input data_t exp, input data_t got);
        errors++;
        $display("ERR %0t %s expected %h got %h", $time, sig, exp, got);
    endfunction

    function automatic void report_fault(input string what);
        errors++;
        $display("%0t: %s", $time, what);
    endfunction

    a_r_data: assert property (@(posedge clock) m_r.valid && m_r_ready && exp_r_on
        |-> m_r.data == exp_r_data)
        else report_mismatch("m_r.data", $sampled(exp_r_data), $sampled(m_r.data));
    a_r_resp: assert property (@(posedge clock) m_r.valid && m_r_ready
        |-> m_r.resp == exp_r_resp)
        else report_mismatch("m_r.resp", 32'($sampled(exp_r_resp)), 32'($sampled(m_r.resp)));
    a_b_resp: assert property (@(posedge clock) m_b.valid && m_b_ready
        |-> m_b.resp == exp_b_resp)
        else report_mismatch("m_b.resp", 32'($sampled(exp_b_resp)), 32'($sampled(m_b.resp)));

    // One cycle from handshake to response.
    a_r_latency: assert property (@(posedge clock) rd_hs |=> m_r.valid)
        else report_fault("read response did not follow the AR handshake by one cycle");
    a_b_latency: assert property (@(posedge clock) wr_hs |=> m_b.valid)
        else report_fault("write response did not follow the write handshake by one cycle");
    a_r_hold: assert property (@(posedge clock) m_r.valid && !m_r_ready
        |=> m_r.valid && $stable(m_r.data) && $stable(m_r.resp))
        else report_fault("read response dropped or changed while r_ready was low");
    a_b_hold: assert property (@(posedge clock) m_b.valid && !m_b_ready
        |=> m_b.valid && $stable(m_b.resp))
        else report_fault("write response dropped or changed while b_ready was low");
    a_ar_blocked: assert property (@(posedge clock) m_r.valid |-> !m_ar_ready)
        else report_fault("m_ar_ready high while a read response was pending");
    a_aw_blocked: assert property (@(posedge clock) m_b.valid |-> !m_aw_ready && !m_w_ready)
        else report_fault("m_aw_ready or m_w_ready high while a write response was pending");

    a_tx_pulse: assert property (@(posedge clock) tx_hs |=> uart_out_valid)
        else report_fault("no uart_out_valid pulse after a transmit write");
    a_tx_char: assert property (@(posedge clock) tx_hs |=> uart_out_ch == last_tx_ch)
        else report_mismatch("uart_out_ch", 32'($sampled(last_tx_ch)),
            32'($sampled(uart_out_ch)));
    a_tx_only: assert property (@(posedge clock) !tx_hs |=> !uart_out_valid)
        else report_fault("uart_out_valid without a transmit write");
    a_rx_valid: assert property (@(posedge clock) uart_in_valid == rx_hs)
        else report_fault("uart_in_valid does not match the RX_DATA read handshake");
    a_rx_data: assert property (@(posedge clock) rx_hs |=> m_r.data == {24'd0, rx_ch_seen})
        else report_mismatch("m_r.data", {24'd0, $sampled(rx_ch_seen)}, $sampled(m_r.data));

    a_reset_quiet: assert property (@(posedge clock) cycles > 0 && since_rel < STAGES
        |-> !m_r.valid && !m_b.valid && !m_ar_ready && !m_aw_ready && !m_w_ready
            && !uart_out_valid && !uart_in_valid)
        else report_fault("outputs active during reset or before its release settled");

    task automatic read_bus(input addr_t addr, input logic check, input data_t data,
                            input axi_resp_e resp);
        @(posedge clock);
        exp_r_on   = check;
        exp_r_data = data;
        exp_r_resp = resp;
        m_ar <= '{valid: 1'b1, addr: addr};
        do @(negedge clock); while (!m_ar_ready);
        @(posedge clock);
        m_ar.valid <= 1'b0;
        do @(negedge clock); while (!(m_r.valid && m_r_ready));
    endtask

    task automatic write_bus(input addr_t addr, input data_t data, input logic [3:0] strb,
                             input axi_resp_e resp);
        @(posedge clock);
        exp_b_resp = resp;
        last_tx_ch = data[7:0];
        m_aw <= '{valid: 1'b1, addr: addr};
        m_w  <= '{valid: 1'b1, data: data, strb: strb};
        do @(negedge clock); while (!m_aw_ready);
        @(posedge clock);
        m_aw.valid <= 1'b0;
        m_w.valid  <= 1'b0;
        do @(negedge clock); while (!(m_b.valid && m_b_ready));
    endtask

    function automatic addr_t ram_addr(input int idx);
        return MEM_BASE + addr_t'(idx) * 4;
    endfunction

    // Byte lanes with strb set take the new data.
    function automatic data_t merge_bytes(input data_t old, input data_t wdata,
                                          input logic [3:0] strb);
        data_t res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        return res;
    endfunction

    task automatic ram_write(input int idx, input data_t data, input logic [3:0] strb);
        write_bus(ram_addr(idx), data, strb, RESP_OKAY);
        ref_mem[idx] = merge_bytes(ref_mem[idx], data, strb);
    endtask

    // The second write waits on AW while the first response is pending.
    task automatic ram_write_pair(input int idx0, input int idx1);
        data_t      d0, d1;
        logic [3:0] s0, s1;
        d0 = $urandom;
        d1 = $urandom;
        s0 = 4'($urandom);
        s1 = 4'($urandom);
        @(posedge clock);
        exp_b_resp = RESP_OKAY;
        m_aw <= '{valid: 1'b1, addr: ram_addr(idx0)};
        m_w  <= '{valid: 1'b1, data: d0, strb: s0};
        do @(negedge clock); while (!m_aw_ready);
        @(posedge clock);
        m_aw <= '{valid: 1'b1, addr: ram_addr(idx1)};
        m_w  <= '{valid: 1'b1, data: d1, strb: s1};
        do @(negedge clock); while (!m_aw_ready);
        @(posedge clock);
        m_aw.valid <= 1'b0;
        m_w.valid  <= 1'b0;
        do @(negedge clock); while (!(m_b.valid && m_b_ready));
        ref_mem[idx0] = merge_bytes(ref_mem[idx0], d0, s0);
        ref_mem[idx1] = merge_bytes(ref_mem[idx1], d1, s1);
    endtask

    task automatic ram_read(input int idx);
        read_bus(ram_addr(idx), 1'b1, ref_mem[idx], RESP_OKAY);
    endtask

    task automatic uart_tx(input data_t data, input logic [3:0] strb);
        write_bus(UART_BASE + 32'(UART_TX_DATA), data, strb, RESP_OKAY);
        tx_sent++;
    endtask

    task automatic close_test(input string name, input int errs_before);
        repeat (2) @(posedge clock);
        if (errors == errs_before) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    initial begin
        int    mark;
        int    idx;
        addr_t a;
        void'($urandom(32'ha702));

        mark = errors;
        repeat (16) @(posedge clock);
        rst_n <= 1'b1;
        repeat (STAGES + 2) @(posedge clock);
        close_test("reset", mark);

        // Pool words get full writes first so every byte is known.
        mark = errors;
        ready_pct = 70;
        for (int i = 0; i < POOL; i++) begin
            pool_idx[i] = $urandom % MEM_WORDS;
            ram_write(pool_idx[i], $urandom, 4'hF);
        end
        for (int i = 0; i < 100; i++) begin
            idx = pool_idx[$urandom % POOL];
            ram_write(idx, $urandom, 4'($urandom));
            if (i % 2 == 1) begin
                ram_read(pool_idx[$urandom % POOL]);
            end
        end
        close_test("ram_rw", mark);

        mark = errors;
        ready_pct = 30;
        for (int i = 0; i < 10; i++) begin
            ram_write_pair(pool_idx[$urandom % POOL], pool_idx[$urandom % POOL]);
            ram_read(pool_idx[$urandom % POOL]);
        end
        close_test("latency_backpressure", mark);

        mark = errors;
        ready_pct = 70;
        for (int i = 0; i < 10; i++) begin
            uart_tx($urandom, 4'($urandom) | 4'h1);
            if (i % 3 == 2) begin
                read_bus(UART_BASE + 32'(UART_STATUS), 1'b1, 32'(tx_sent), RESP_OKAY);
            end
        end
        close_test("uart_tx", mark);

        mark = errors;
        for (int i = 0; i < 8; i++) begin
            read_bus(UART_BASE + 32'(UART_RX_DATA), 1'b0, '0, RESP_OKAY);
        end
        close_test("uart_rx", mark);

        // Unmapped space, window edges and an unused UART offset.
        mark = errors;
        for (int i = 0; i < 4; i++) begin
            a = 32'h4000_0000 + addr_t'(($urandom % 4096) * 4);
            read_bus(a, 1'b1, '0, RESP_DECERR);
            write_bus(a, $urandom, 4'hF, RESP_DECERR);
        end
        read_bus(MEM_BASE + addr_t'(4 * MEM_WORDS), 1'b1, '0, RESP_DECERR);
        write_bus(UART_BASE + UART_SPAN, $urandom, 4'hF, RESP_DECERR);
        read_bus(UART_BASE + 32'hC, 1'b1, '0, RESP_SLVERR);
        write_bus(UART_BASE + 32'(UART_STATUS), $urandom, 4'hF, RESP_SLVERR);
        read_bus(UART_BASE + 32'(UART_STATUS), 1'b1, 32'(tx_sent), RESP_OKAY);
        for (int i = 0; i < POOL; i++) begin
            ram_read(pool_idx[i]);
        end
        close_test("errors", mark);

        repeat (4) @(posedge clock);
        $display("tests ok: %0d, tests with errors: %0d, failed checks: %0d",
                 tests_ok, tests_bad, errors);
        if (errors == 0 && tests_bad == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
